//--- cnn_accel_pkg.sv
package cnn_accel_pkg;

    //////////////////////
    // Sizes
    //////////////////////
    localparam int ROW_ADDR_W      = 10;
    localparam int NUM_AWE         = 4;
    localparam int NUM_CE_PER_AWE  = 2;
    localparam int NUM_CE          = NUM_AWE * NUM_CE_PER_AWE;
    localparam int SEQ_ADDR_W      = 12;
    localparam int KERNEL_W        = 4;

    // 3x3 window, one sequence read per tap
    localparam int WINDOW_CYCLES   = 9;
    localparam int CYC_W           = 4;

    //////////////////////
    // Latencies
    //////////////////////
    localparam int PRIME_ROWS      = 3;
    localparam int SEQ_RD_LATENCY  = 3;

    //////////////////////
    // Job FSM encodings
    //////////////////////
    localparam int STATE_W = 6;

    localparam logic [STATE_W-1:0] ST_IDLE          = 6'b000001;
    localparam logic [STATE_W-1:0] ST_PRIME         = 6'b000010;
    localparam logic [STATE_W-1:0] ST_WAIT_LOAD     = 6'b000100;
    localparam logic [STATE_W-1:0] ST_ACTIVE        = 6'b001000;
    localparam logic [STATE_W-1:0] ST_WAIT_DONE     = 6'b010000;
    localparam logic [STATE_W-1:0] ST_SEND_COMPLETE = 6'b100000;

endpackage

//--- row_fill_seq.sv
`timescale 1ns/1ps

module row_fill_seq (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 row_load,
    input  logic                                 job_clear,
    input  logic [cnn_accel_pkg::ROW_ADDR_W-1:0] num_expd_input_cols,
    output logic                                 pfb_rden,
    output logic [cnn_accel_pkg::ROW_ADDR_W-1:0] input_row,
    output logic [cnn_accel_pkg::ROW_ADDR_W-1:0] input_col,
    output logic                                 row_drained
);

    import cnn_accel_pkg::*;

    // One extra bit, a row holds C+1 words
    logic [ROW_ADDR_W:0] words_left;
    logic                last_word;

    assign pfb_rden  = (words_left != '0);
    assign last_word = (words_left == (ROW_ADDR_W + 1)'(1));

    //////////////////////
    // Buffer drain
    //////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            words_left <= '0;
        end else if (row_load) begin
            words_left <= {1'b0, num_expd_input_cols} + 1'b1;
        end else if (pfb_rden) begin
            words_left <= words_left - 1'b1;
        end
    end

    // Pulse once the final word has gone out
    always_ff @(posedge clk) begin
        if (rst) begin
            row_drained <= 1'b0;
        end else begin
            row_drained <= pfb_rden && last_word;
        end
    end

    //////////////////////
    // Input position
    //////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            input_row <= '0;
            input_col <= '0;
        end else if (job_clear) begin
            input_row <= '0;
            input_col <= '0;
        end else if (pfb_rden) begin
            if (last_word) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

endmodule

//--- ce_strobe_chain.sv
`timescale 1ns/1ps

module ce_strobe_chain (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             seq_rden,
    input  logic                             window_end,
    output logic [cnn_accel_pkg::NUM_CE-1:0] ce_execute,
    output logic [cnn_accel_pkg::NUM_CE-1:0] next_kernel
);

    import cnn_accel_pkg::*;

    // Low bits cover the BRAM latency, the rest is one tap per CE
    logic [SEQ_RD_LATENCY+NUM_CE-2:0] exec_sr;
    logic [SEQ_RD_LATENCY+NUM_CE-2:0] kern_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_sr <= '0;
            kern_sr <= '0;
        end else begin
            exec_sr <= {exec_sr[SEQ_RD_LATENCY+NUM_CE-3:0], seq_rden};
            kern_sr <= {kern_sr[SEQ_RD_LATENCY+NUM_CE-3:0], window_end};
        end
    end

    // CE 0 sees data SEQ_RD_LATENCY cycles after the read
    assign ce_execute  = exec_sr[SEQ_RD_LATENCY+NUM_CE-2 -: NUM_CE];
    assign next_kernel = kern_sr[SEQ_RD_LATENCY+NUM_CE-2 -: NUM_CE];

endmodule

//--- window_seq.sv
`timescale 1ns/1ps

module window_seq (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 pass_start,
    input  logic [cnn_accel_pkg::SEQ_ADDR_W-1:0] pix_seq_data_full_count,
    input  logic [cnn_accel_pkg::KERNEL_W-1:0]   num_kernels,
    output logic                                 pix_seq_bram_rden,
    output logic [cnn_accel_pkg::SEQ_ADDR_W-1:0] pix_seq_bram_rdaddr,
    output logic [cnn_accel_pkg::CYC_W-1:0]      cycle_counter,
    output logic                                 ctrl_last_kernel,
    output logic [cnn_accel_pkg::NUM_CE-1:0]     ce_execute,
    output logic [cnn_accel_pkg::NUM_CE-1:0]     next_kernel,
    output logic                                 pass_done
);

    import cnn_accel_pkg::*;

    logic [SEQ_ADDR_W-1:0] reads_left;
    logic [KERNEL_W-1:0]   kernel_group;
    logic                  window_end;

    assign pix_seq_bram_rden = (reads_left != '0);
    assign window_end        = pix_seq_bram_rden &&
                               (cycle_counter == CYC_W'(WINDOW_CYCLES - 1));
    assign ctrl_last_kernel  = (kernel_group == num_kernels);

    //////////////////////
    // Sequence reads
    //////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            reads_left          <= '0;
            pix_seq_bram_rdaddr <= '0;
        end else if (pass_start) begin
            reads_left          <= pix_seq_data_full_count;
            pix_seq_bram_rdaddr <= '0;
        end else if (pix_seq_bram_rden) begin
            reads_left          <= reads_left - 1'b1;
            pix_seq_bram_rdaddr <= pix_seq_bram_rdaddr + 1'b1;
        end
    end

    // Tap position inside the current window
    always_ff @(posedge clk) begin
        if (rst || pass_start) begin
            cycle_counter <= '0;
        end else if (window_end) begin
            cycle_counter <= '0;
        end else if (pix_seq_bram_rden) begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

    // Kernel group runs on across passes
    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_group <= '0;
        end else if (window_end) begin
            if (kernel_group == num_kernels) begin
                kernel_group <= '0;
            end else begin
                kernel_group <= kernel_group + 1'b1;
            end
        end
    end

    ce_strobe_chain u_ce_strobe_chain (
        .clk         (clk),
        .rst         (rst),
        .seq_rden    (pix_seq_bram_rden),
        .window_end  (window_end),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel)
    );

    // Tail of the execute run leaving the last CE
    always_ff @(posedge clk) begin
        if (rst) begin
            pass_done <= 1'b0;
        end else begin
            pass_done <= ce_execute[NUM_CE-1] && !ce_execute[NUM_CE-2];
        end
    end

endmodule

//--- job_ctrl.sv
`timescale 1ns/1ps

module job_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 job_start,
    output logic                                 job_accept,
    output logic                                 job_fetch_request,
    input  logic                                 job_fetch_ack,
    input  logic                                 job_fetch_complete,
    output logic                                 job_complete,
    input  logic                                 job_complete_ack,
    input  logic                                 pipeline_flushed,
    input  logic [cnn_accel_pkg::ROW_ADDR_W-1:0] input_row,
    input  logic [cnn_accel_pkg::ROW_ADDR_W-1:0] num_expd_input_rows,
    input  logic                                 row_drained,
    input  logic                                 pass_done,
    output logic                                 row_load,
    output logic                                 job_clear,
    output logic                                 pass_start,
    output logic [cnn_accel_pkg::STATE_W-1:0]    state,
    output logic [1:0]                           gray_code
);

    import cnn_accel_pkg::*;

    logic       fetch_acked;
    logic       row_busy;
    logic       loading;
    logic [1:0] pass_cnt;

    // Both states bring one row into the prefetch buffer
    assign loading   = (state == ST_PRIME) || (state == ST_WAIT_LOAD);
    assign gray_code = {pass_cnt[1], pass_cnt[1] ^ pass_cnt[0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            fetch_acked       <= 1'b0;
            row_busy          <= 1'b0;
            row_load          <= 1'b0;
            job_clear         <= 1'b0;
            pass_start        <= 1'b0;
            pass_cnt          <= '0;
        end else begin
            job_accept <= 1'b0;
            row_load   <= 1'b0;
            job_clear  <= 1'b0;
            pass_start <= 1'b0;

            //////////////////////
            // Fetch then drain
            //////////////////////
            if (loading && !row_busy) begin
                if (!fetch_acked) begin
                    if (job_fetch_request && job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        fetch_acked       <= 1'b1;
                    end else begin
                        job_fetch_request <= 1'b1;
                    end
                end else if (job_fetch_complete) begin
                    // Row is in the buffer now
                    fetch_acked <= 1'b0;
                    row_load    <= 1'b1;
                    row_busy    <= 1'b1;
                end
            end

            //////////////////////
            // Job FSM
            //////////////////////
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    if (row_busy && row_drained) begin
                        row_busy <= 1'b0;
                        if (input_row == ROW_ADDR_W'(PRIME_ROWS)) begin
                            pass_start <= 1'b1;
                            state      <= ST_ACTIVE;
                        end
                    end
                end
                ST_WAIT_LOAD: begin
                    if (row_busy && row_drained) begin
                        row_busy   <= 1'b0;
                        pass_cnt   <= pass_cnt + 1'b1;
                        pass_start <= 1'b1;
                        state      <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    if (pass_done) begin
                        // More input rows left to bring in
                        if (input_row <= num_expd_input_rows) begin
                            state <= ST_WAIT_LOAD;
                        end else begin
                            state <= ST_WAIT_DONE;
                        end
                    end
                end
                ST_WAIT_DONE: begin
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= ST_SEND_COMPLETE;
                    end
                end
                ST_SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        job_clear    <= 1'b1;
                        pass_cnt     <= '0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- cnn_quad_bram_ctrl.sv
`timescale 1ns/1ps

module cnn_quad_bram_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [cnn_accel_pkg::ROW_ADDR_W-1:0] num_expd_input_cols,
    input  logic [cnn_accel_pkg::ROW_ADDR_W-1:0] num_expd_input_rows,
    input  logic [cnn_accel_pkg::KERNEL_W-1:0]   num_kernels,
    input  logic [cnn_accel_pkg::SEQ_ADDR_W-1:0] pix_seq_data_full_count,
    input  logic                                 job_start,
    output logic                                 job_accept,
    output logic                                 job_fetch_request,
    input  logic                                 job_fetch_ack,
    input  logic                                 job_fetch_complete,
    output logic                                 job_complete,
    input  logic                                 job_complete_ack,
    input  logic                                 pipeline_flushed,
    output logic [cnn_accel_pkg::STATE_W-1:0]    state,
    output logic [cnn_accel_pkg::ROW_ADDR_W-1:0] input_row,
    output logic [cnn_accel_pkg::ROW_ADDR_W-1:0] input_col,
    output logic [1:0]                           gray_code,
    output logic                                 pfb_rden,
    output logic                                 pix_seq_bram_rden,
    output logic [cnn_accel_pkg::SEQ_ADDR_W-1:0] pix_seq_bram_rdaddr,
    output logic [cnn_accel_pkg::CYC_W-1:0]      cycle_counter,
    output logic                                 ctrl_last_kernel,
    output logic [cnn_accel_pkg::NUM_CE-1:0]     ce_execute,
    output logic [cnn_accel_pkg::NUM_CE-1:0]     next_kernel
);

    import cnn_accel_pkg::*;

    // Row side
    logic row_load;
    logic job_clear;
    logic row_drained;

    // Window side
    logic pass_start;
    logic pass_done;

    row_fill_seq u_row_fill_seq (
        .clk                 (clk),
        .rst                 (rst),
        .row_load            (row_load),
        .job_clear           (job_clear),
        .num_expd_input_cols (num_expd_input_cols),
        .pfb_rden            (pfb_rden),
        .input_row           (input_row),
        .input_col           (input_col),
        .row_drained         (row_drained)
    );

    window_seq u_window_seq (
        .clk                     (clk),
        .rst                     (rst),
        .pass_start              (pass_start),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .num_kernels             (num_kernels),
        .pix_seq_bram_rden       (pix_seq_bram_rden),
        .pix_seq_bram_rdaddr     (pix_seq_bram_rdaddr),
        .cycle_counter           (cycle_counter),
        .ctrl_last_kernel        (ctrl_last_kernel),
        .ce_execute              (ce_execute),
        .next_kernel             (next_kernel),
        .pass_done               (pass_done)
    );

    job_ctrl u_job_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .job_start           (job_start),
        .job_accept          (job_accept),
        .job_fetch_request   (job_fetch_request),
        .job_fetch_ack       (job_fetch_ack),
        .job_fetch_complete  (job_fetch_complete),
        .job_complete        (job_complete),
        .job_complete_ack    (job_complete_ack),
        .pipeline_flushed    (pipeline_flushed),
        .input_row           (input_row),
        .num_expd_input_rows (num_expd_input_rows),
        .row_drained         (row_drained),
        .pass_done           (pass_done),
        .row_load            (row_load),
        .job_clear           (job_clear),
        .pass_start          (pass_start),
        .state               (state),
        .gray_code           (gray_code)
    );

endmodule

//--- cnn_quad_bram_ctrl_sva.sv
`timescale 1ns/1ps

module cnn_quad_bram_ctrl_sva (
    input logic                             clk,
    input logic                             rst,
    input logic [cnn_accel_pkg::NUM_CE-1:0] ce_execute,
    input logic                             job_fetch_request,
    input logic                             job_fetch_ack,
    input logic                             pfb_rden,
    input logic                             pix_seq_bram_rden
);

    import cnn_accel_pkg::*;

    // Count of failed assertions
    int assert_errors = 0;

    // Execute strobe moves one CE per cycle
    for (genvar k = 1; k < NUM_CE; k++) begin : g_chain
        a_chain: assert property (@(posedge clk) disable iff (rst)
            ce_execute[k] == $past(ce_execute[k-1]))
            else begin
                $error("ce_execute[%0d] does not follow its neighbour", k);
                assert_errors++;
            end
    end

    a_fetch_drop: assert property (@(posedge clk) disable iff (rst)
        $fell(job_fetch_request) |-> $past(job_fetch_ack))
        else begin
            $error("fetch request dropped without an ack");
            assert_errors++;
        end

    a_rden_excl: assert property (@(posedge clk) disable iff (rst)
        !(pfb_rden && pix_seq_bram_rden))
        else begin
            $error("buffer and sequence reads overlap");
            assert_errors++;
        end

endmodule

bind cnn_quad_bram_ctrl cnn_quad_bram_ctrl_sva u_cnn_quad_bram_ctrl_sva (.*);

//--- tb_cnn_quad_bram_ctrl.sv
`timescale 1ns/1ps

module tb_cnn_quad_bram_ctrl;

    import cnn_accel_pkg::*;

    // C, R-1, N, num_kernels, fetches, buffer reads, passes, sequence reads
    // Every job ends on a whole kernel group
    localparam int NUM_JOBS = 6;
    localparam int JOBS [NUM_JOBS][8] = '{
        '{3, 3, 18, 1, 4, 16, 2,  36},
        '{5, 4, 27, 2, 5, 30, 3,  81},
        '{0, 5,  9, 0, 6,  6, 4,  36},
        '{7, 6, 20, 4, 7, 56, 5, 100},
        '{2, 3, 10, 0, 4, 12, 2,  20},
        '{4, 7, 36, 1, 8, 40, 6, 216}
    };

    // Gray code of successive passes
    localparam logic [1:0] GRAY_SEQ [4] = '{2'b00, 2'b01, 2'b11, 2'b10};
    localparam int HIST_W = SEQ_RD_LATENCY + NUM_CE - 1;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [ROW_ADDR_W-1:0] num_expd_input_cols;
    logic [ROW_ADDR_W-1:0] num_expd_input_rows;
    logic [ROW_ADDR_W-1:0] input_row;
    logic [ROW_ADDR_W-1:0] input_col;
    logic [KERNEL_W-1:0]   num_kernels;
    logic [SEQ_ADDR_W-1:0] pix_seq_data_full_count;
    logic [SEQ_ADDR_W-1:0] pix_seq_bram_rdaddr;
    logic                  job_start;
    logic                  job_accept;
    logic                  job_fetch_request;
    logic                  job_fetch_ack;
    logic                  job_fetch_complete;
    logic                  job_complete;
    logic                  job_complete_ack;
    logic                  pipeline_flushed;
    logic                  pfb_rden;
    logic                  pix_seq_bram_rden;
    logic                  ctrl_last_kernel;
    logic [STATE_W-1:0]    state;
    logic [1:0]            gray_code;
    logic [CYC_W-1:0]      cycle_counter;
    logic [NUM_CE-1:0]     ce_execute;
    logic [NUM_CE-1:0]     next_kernel;

    logic [31:0] lfsr = 32'h9a21_5cb1;
    int n_accept;
    int n_fetch;
    int n_pfb;
    int n_seq;
    int n_pass;
    int n_kern;
    int n_win;
    int col_exp;
    int addr_exp;
    int cur_c;
    int cur_n;
    int cur_nk;
    logic prev_rden;
    logic prev_cmp;
    logic prev_cmp_ack;
    logic [HIST_W-1:0] rden_hist = '0;
    logic [HIST_W-1:0] wend_hist = '0;

    always #50 clk = ~clk;

    cnn_quad_bram_ctrl u_cnn_quad_bram_ctrl (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // CE k sees a strobe SEQ_RD_LATENCY + k cycles after it is issued
    function automatic logic [NUM_CE-1:0] delayed_taps(input logic [HIST_W-1:0] hist);
        logic [NUM_CE-1:0] taps;
        for (int k = 0; k < NUM_CE; k++) begin
            taps[k] = hist[SEQ_RD_LATENCY+k-1];
        end
        return taps;
    endfunction

    // Three LFSR bits give 0 to 7 idle cycles
    task automatic rand_delay(output int d);
        d = 0;
        repeat (3) begin
            lfsr = lfsr_step(lfsr);
            d = (d << 1) | lfsr[0];
        end
    endtask

    task automatic check(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    //////////////////////
    // Responders
    //////////////////////
    always begin : fetch_responder
        int d;
        @(negedge clk);
        if (job_fetch_request) begin
            rand_delay(d);
            repeat (d) @(posedge clk);
            @(posedge clk) job_fetch_ack <= 1'b1;
            @(posedge clk) job_fetch_ack <= 1'b0;
            rand_delay(d);
            repeat (d) @(posedge clk);
            @(posedge clk) job_fetch_complete <= 1'b1;
            @(posedge clk) job_fetch_complete <= 1'b0;
        end
    end

    always begin : complete_responder
        int d;
        @(negedge clk);
        if (state == ST_WAIT_DONE) begin
            rand_delay(d);
            repeat (d) @(posedge clk);
            @(posedge clk) pipeline_flushed <= 1'b1;
            do @(negedge clk); while (!job_complete);
            @(posedge clk) pipeline_flushed <= 1'b0;
            rand_delay(d);
            repeat (d) @(posedge clk);
            @(posedge clk) job_complete_ack <= 1'b1;
            @(posedge clk) job_complete_ack <= 1'b0;
        end
    end

    //////////////////////
    // Mid-cycle monitor
    //////////////////////
    always @(negedge clk) begin : monitor
        logic wend;
        wend = 1'b0;
        if (!rst) begin
            if (u_cnn_quad_bram_ctrl.u_cnn_quad_bram_ctrl_sva.assert_errors != 0) begin
                $display("A bound assertion on the DUT failed");
                $display("CHECKS FAILED");
                $fatal(1);
            end
            n_accept += job_accept;
            n_fetch  += (job_fetch_request && job_fetch_ack);
            n_kern   += next_kernel[0];
            check("ce_execute", delayed_taps(rden_hist), ce_execute);
            check("next_kernel", delayed_taps(wend_hist), next_kernel);
            if (prev_cmp)
                check("complete hold", !prev_cmp_ack, job_complete);
            if (pfb_rden) begin
                check("input_col", col_exp, input_col);
                col_exp = (col_exp == cur_c) ? 0 : col_exp + 1;
                n_pfb++;
            end
            if (pix_seq_bram_rden) begin
                if (!prev_rden) begin
                    check("gray_code", GRAY_SEQ[n_pass % 4], gray_code);
                    n_pass++;
                    addr_exp = 0;
                end
                check("rdaddr", addr_exp, pix_seq_bram_rdaddr);
                check("cycle_counter", addr_exp % WINDOW_CYCLES, cycle_counter);
                // Last tap of a window, group number counted from the job start
                if (addr_exp % WINDOW_CYCLES == WINDOW_CYCLES - 1) begin
                    wend = 1'b1;
                    check("last_kernel", (n_win % (cur_nk + 1)) == cur_nk, ctrl_last_kernel);
                    n_win++;
                end
                addr_exp++;
                n_seq++;
            end else if (prev_rden) begin
                check("pass length", cur_n, addr_exp);
            end
            rden_hist = {rden_hist[HIST_W-2:0], pix_seq_bram_rden};
            wend_hist = {wend_hist[HIST_W-2:0], wend};
        end
        prev_rden    = pix_seq_bram_rden;
        prev_cmp     = job_complete;
        prev_cmp_ack = job_complete_ack;
    end

    initial begin : watchdog
        longint budget;
        int r;
        budget = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            r = JOBS[j][1] + 1;
            budget += r * (JOBS[j][0] + 1) + (r - 2) * (JOBS[j][2] + 20) + 16 * r + 100;
        end
        #(budget * 100);
        $display("Timeout: a job did not finish in the allowed time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        rst = 1'b1;
        job_start = 1'b0;
        job_fetch_ack = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack = 1'b0;
        pipeline_flushed = 1'b0;
        num_expd_input_cols = '0;
        num_expd_input_rows = '0;
        num_kernels = '0;
        pix_seq_data_full_count = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            @(posedge clk);
            n_accept = 0;
            n_fetch  = 0;
            n_pfb    = 0;
            n_seq    = 0;
            n_pass   = 0;
            n_kern   = 0;
            n_win    = 0;
            col_exp  = 0;
            cur_c    = JOBS[j][0];
            cur_n    = JOBS[j][2];
            cur_nk   = JOBS[j][3];
            num_expd_input_cols     <= JOBS[j][0];
            num_expd_input_rows     <= JOBS[j][1];
            pix_seq_data_full_count <= JOBS[j][2];
            num_kernels             <= JOBS[j][3];
            job_start               <= 1'b1;
            do @(negedge clk); while (!job_accept);
            @(posedge clk) job_start <= 1'b0;
            do @(negedge clk); while (!job_complete);
            check("input_row", JOBS[j][1] + 1, input_row);
            do @(negedge clk); while (job_complete);
            check("idle state", ST_IDLE, state);
            check("gray after job", 0, gray_code);
            check("accepts", 1, n_accept);
            check("fetches", JOBS[j][4], n_fetch);
            check("buffer reads", JOBS[j][5], n_pfb);
            check("passes", JOBS[j][6], n_pass);
            check("sequence reads", JOBS[j][7], n_seq);
            check("next_kernel", JOBS[j][6] * (JOBS[j][2] / 9), n_kern);
        end
        if (u_cnn_quad_bram_ctrl.u_cnn_quad_bram_ctrl_sva.assert_errors != 0) begin
            $display("A bound assertion on the DUT failed");
            $display("CHECKS FAILED");
            $fatal(1);
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- vlog.f
cnn_accel_pkg.sv
row_fill_seq.sv
ce_strobe_chain.sv
window_seq.sv
job_ctrl.sv
cnn_quad_bram_ctrl.sv
cnn_quad_bram_ctrl_sva.sv
tb_cnn_quad_bram_ctrl.sv
